//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // ALU funct3, shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // JALR has a single legal encoding
    localparam funct3_t F3_JALR = 3'b000;

    // Branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Load widths, bit 2 marks zero extension
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // Store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // funct7 modifiers, ALT selects SUB and SRA
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage : rv_isa_pkg

`default_nettype wire

//--- design/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    // Control word widths
    localparam int CLASS_W   = 4;
    localparam int ALU_OP_W  = 5;
    localparam int IMM_SEL_W = 3;
    localparam int RES_SEL_W = 2;

    typedef logic [CLASS_W-1:0]   instr_class_t;
    typedef logic [ALU_OP_W-1:0]  alu_op_t;
    typedef logic [IMM_SEL_W-1:0] imm_sel_t;
    typedef logic [RES_SEL_W-1:0] result_sel_t;

    // Instruction classes seen by the funct decoder
    localparam instr_class_t CLS_ILLEGAL = 4'd0;
    localparam instr_class_t CLS_LUI     = 4'd1;
    localparam instr_class_t CLS_AUIPC   = 4'd2;
    localparam instr_class_t CLS_JAL     = 4'd3;
    localparam instr_class_t CLS_JALR    = 4'd4;
    localparam instr_class_t CLS_BRANCH  = 4'd5;
    localparam instr_class_t CLS_LOAD    = 4'd6;
    localparam instr_class_t CLS_STORE   = 4'd7;
    localparam instr_class_t CLS_OP_IMM  = 4'd8;
    localparam instr_class_t CLS_OP      = 4'd9;

    // Arithmetic and logic operations
    localparam alu_op_t ALU_ADD    = 5'd0;
    localparam alu_op_t ALU_SUB    = 5'd1;
    localparam alu_op_t ALU_SLL    = 5'd2;
    localparam alu_op_t ALU_SLT    = 5'd3;
    localparam alu_op_t ALU_SLTU   = 5'd4;
    localparam alu_op_t ALU_XOR    = 5'd5;
    localparam alu_op_t ALU_SRL    = 5'd6;
    localparam alu_op_t ALU_SRA    = 5'd7;
    localparam alu_op_t ALU_OR     = 5'd8;
    localparam alu_op_t ALU_AND    = 5'd9;
    // Forwards operand B, used by LUI
    localparam alu_op_t ALU_PASS_B = 5'd10;

    // Branch compares
    localparam alu_op_t ALU_EQ  = 5'd11;
    localparam alu_op_t ALU_NE  = 5'd12;
    localparam alu_op_t ALU_LT  = 5'd13;
    localparam alu_op_t ALU_GE  = 5'd14;
    localparam alu_op_t ALU_LTU = 5'd15;
    localparam alu_op_t ALU_GEU = 5'd16;

    // Immediate formats
    localparam imm_sel_t IMM_I     = 3'd0;
    localparam imm_sel_t IMM_S     = 3'd1;
    localparam imm_sel_t IMM_B     = 3'd2;
    localparam imm_sel_t IMM_U     = 3'd3;
    localparam imm_sel_t IMM_J     = 3'd4;
    localparam imm_sel_t IMM_SHAMT = 3'd5;

    // Writeback source
    localparam result_sel_t RES_ALU = 2'd0;
    localparam result_sel_t RES_MEM = 2'd1;
    localparam result_sel_t RES_PC4 = 2'd2;

    // ALU operand muxes
    localparam logic SRC_A_RS1 = 1'b0;
    localparam logic SRC_A_PC  = 1'b1;
    localparam logic SRC_B_RS2 = 1'b0;
    localparam logic SRC_B_IMM = 1'b1;

endpackage : decode_ctrl_pkg

`default_nettype wire

//--- design/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder (
    input  var rv_isa_pkg::opcode_t          opcode,
    input  var logic                         funct_legal,
    output decode_ctrl_pkg::instr_class_t    instr_class,
    output logic                             reg_write,
    output logic                             mem_write_en,
    output logic                             jump,
    output logic                             branch,
    output logic                             jalr_target,
    output logic                             alu_src_sel_a,
    output logic                             alu_src_sel_b,
    output logic                             err,
    output decode_ctrl_pkg::result_sel_t     result_sel
);

    // Opcode to class, FENCE and SYSTEM fall through to illegal
    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_LUI:    instr_class = decode_ctrl_pkg::CLS_LUI;
            rv_isa_pkg::OPC_AUIPC:  instr_class = decode_ctrl_pkg::CLS_AUIPC;
            rv_isa_pkg::OPC_JAL:    instr_class = decode_ctrl_pkg::CLS_JAL;
            rv_isa_pkg::OPC_JALR:   instr_class = decode_ctrl_pkg::CLS_JALR;
            rv_isa_pkg::OPC_BRANCH: instr_class = decode_ctrl_pkg::CLS_BRANCH;
            rv_isa_pkg::OPC_LOAD:   instr_class = decode_ctrl_pkg::CLS_LOAD;
            rv_isa_pkg::OPC_STORE:  instr_class = decode_ctrl_pkg::CLS_STORE;
            rv_isa_pkg::OPC_OP_IMM: instr_class = decode_ctrl_pkg::CLS_OP_IMM;
            rv_isa_pkg::OPC_OP:     instr_class = decode_ctrl_pkg::CLS_OP;
            default:                instr_class = decode_ctrl_pkg::CLS_ILLEGAL;
        endcase
    end

    // Unknown opcode or a funct field the class rejects
    assign err = (instr_class == decode_ctrl_pkg::CLS_ILLEGAL) || !funct_legal;

    always_comb begin
        reg_write     = 1'b0;
        mem_write_en  = 1'b0;
        jump          = 1'b0;
        branch        = 1'b0;
        jalr_target   = 1'b0;
        alu_src_sel_a = decode_ctrl_pkg::SRC_A_RS1;
        alu_src_sel_b = decode_ctrl_pkg::SRC_B_RS2;
        result_sel    = decode_ctrl_pkg::RES_ALU;

        // Controls stay at zero while err is raised
        if (!err) begin
            case (instr_class)
                decode_ctrl_pkg::CLS_LUI: begin
                    reg_write     = 1'b1;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                end
                decode_ctrl_pkg::CLS_AUIPC: begin
                    reg_write     = 1'b1;
                    alu_src_sel_a = decode_ctrl_pkg::SRC_A_PC;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                end
                // Target is pc plus immediate, link value is pc+4
                decode_ctrl_pkg::CLS_JAL: begin
                    reg_write     = 1'b1;
                    jump          = 1'b1;
                    alu_src_sel_a = decode_ctrl_pkg::SRC_A_PC;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                    result_sel    = decode_ctrl_pkg::RES_PC4;
                end
                decode_ctrl_pkg::CLS_JALR: begin
                    reg_write     = 1'b1;
                    jump          = 1'b1;
                    jalr_target   = 1'b1;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                    result_sel    = decode_ctrl_pkg::RES_PC4;
                end
                // Compare rs1 against rs2, no writeback
                decode_ctrl_pkg::CLS_BRANCH: begin
                    branch = 1'b1;
                end
                decode_ctrl_pkg::CLS_LOAD: begin
                    reg_write     = 1'b1;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                    result_sel    = decode_ctrl_pkg::RES_MEM;
                end
                // Address is rs1 plus S immediate
                decode_ctrl_pkg::CLS_STORE: begin
                    mem_write_en  = 1'b1;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                end
                decode_ctrl_pkg::CLS_OP_IMM: begin
                    reg_write     = 1'b1;
                    alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
                end
                decode_ctrl_pkg::CLS_OP: begin
                    reg_write = 1'b1;
                end
                default: begin
                    reg_write = 1'b0;
                end
            endcase
        end
    end

    // Sequencer would see two next-pc sources at once
    always_comb begin
        assert final (!(jump && branch))
            else $error("main_decoder: jump and branch both set, opcode %b", opcode);
    end

endmodule : main_decoder

`default_nettype wire

//--- design/funct_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module funct_decoder (
    input  var decode_ctrl_pkg::instr_class_t instr_class,
    input  var rv_isa_pkg::funct3_t           funct3,
    input  var rv_isa_pkg::funct7_t           funct7,
    output decode_ctrl_pkg::alu_op_t          alu_op,
    output decode_ctrl_pkg::imm_sel_t         imm_ctrl,
    output logic                              funct_legal
);

    logic                     sel_legal;
    decode_ctrl_pkg::alu_op_t  sel_op;
    decode_ctrl_pkg::imm_sel_t sel_imm;

    // Per-class funct tables
    always_comb begin
        sel_legal = 1'b1;
        sel_op    = decode_ctrl_pkg::ALU_ADD;
        sel_imm   = decode_ctrl_pkg::IMM_I;

        case (instr_class)
            decode_ctrl_pkg::CLS_LUI: begin
                sel_op  = decode_ctrl_pkg::ALU_PASS_B;
                sel_imm = decode_ctrl_pkg::IMM_U;
            end
            decode_ctrl_pkg::CLS_AUIPC: begin
                sel_imm = decode_ctrl_pkg::IMM_U;
            end
            decode_ctrl_pkg::CLS_JAL: begin
                sel_imm = decode_ctrl_pkg::IMM_J;
            end
            decode_ctrl_pkg::CLS_JALR: begin
                sel_legal = (funct3 == rv_isa_pkg::F3_JALR);
            end
            decode_ctrl_pkg::CLS_BRANCH: begin
                sel_imm = decode_ctrl_pkg::IMM_B;
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  sel_op = decode_ctrl_pkg::ALU_EQ;
                    rv_isa_pkg::F3_BNE:  sel_op = decode_ctrl_pkg::ALU_NE;
                    rv_isa_pkg::F3_BLT:  sel_op = decode_ctrl_pkg::ALU_LT;
                    rv_isa_pkg::F3_BGE:  sel_op = decode_ctrl_pkg::ALU_GE;
                    rv_isa_pkg::F3_BLTU: sel_op = decode_ctrl_pkg::ALU_LTU;
                    rv_isa_pkg::F3_BGEU: sel_op = decode_ctrl_pkg::ALU_GEU;
                    default:             sel_legal = 1'b0;
                endcase
            end
            // Address add only, funct3 just picks the access width
            decode_ctrl_pkg::CLS_LOAD: begin
                case (funct3)
                    rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LW,
                    rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU: sel_legal = 1'b1;
                    default:                                sel_legal = 1'b0;
                endcase
            end
            decode_ctrl_pkg::CLS_STORE: begin
                sel_imm = decode_ctrl_pkg::IMM_S;
                case (funct3)
                    rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH,
                    rv_isa_pkg::F3_SW: sel_legal = 1'b1;
                    default:           sel_legal = 1'b0;
                endcase
            end
            decode_ctrl_pkg::CLS_OP_IMM: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: sel_op = decode_ctrl_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT:     sel_op = decode_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU:    sel_op = decode_ctrl_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:     sel_op = decode_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      sel_op = decode_ctrl_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     sel_op = decode_ctrl_pkg::ALU_AND;
                    // Shift amount sits in the low imm bits, funct7 above it
                    rv_isa_pkg::F3_SLL: begin
                        sel_op    = decode_ctrl_pkg::ALU_SLL;
                        sel_imm   = decode_ctrl_pkg::IMM_SHAMT;
                        sel_legal = (funct7 == rv_isa_pkg::F7_BASE);
                    end
                    default: begin
                        sel_imm = decode_ctrl_pkg::IMM_SHAMT;
                        if (funct7 == rv_isa_pkg::F7_BASE) begin
                            sel_op = decode_ctrl_pkg::ALU_SRL;
                        end else if (funct7 == rv_isa_pkg::F7_ALT) begin
                            sel_op = decode_ctrl_pkg::ALU_SRA;
                        end else begin
                            sel_legal = 1'b0;
                        end
                    end
                endcase
            end
            decode_ctrl_pkg::CLS_OP: begin
                if (funct7 == rv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD_SUB: sel_op = decode_ctrl_pkg::ALU_ADD;
                        rv_isa_pkg::F3_SLL:     sel_op = decode_ctrl_pkg::ALU_SLL;
                        rv_isa_pkg::F3_SLT:     sel_op = decode_ctrl_pkg::ALU_SLT;
                        rv_isa_pkg::F3_SLTU:    sel_op = decode_ctrl_pkg::ALU_SLTU;
                        rv_isa_pkg::F3_XOR:     sel_op = decode_ctrl_pkg::ALU_XOR;
                        rv_isa_pkg::F3_SRL_SRA: sel_op = decode_ctrl_pkg::ALU_SRL;
                        rv_isa_pkg::F3_OR:      sel_op = decode_ctrl_pkg::ALU_OR;
                        default:                sel_op = decode_ctrl_pkg::ALU_AND;
                    endcase
                end else if (funct7 == rv_isa_pkg::F7_ALT
                             && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
                    sel_op = decode_ctrl_pkg::ALU_SUB;
                end else if (funct7 == rv_isa_pkg::F7_ALT
                             && funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    sel_op = decode_ctrl_pkg::ALU_SRA;
                end else begin
                    sel_legal = 1'b0;
                end
            end
            default: begin
                sel_legal = 1'b0;
            end
        endcase
    end

    // Illegal combinations collapse to ADD with the I format
    assign funct_legal = sel_legal;
    assign alu_op      = sel_legal ? sel_op : decode_ctrl_pkg::ALU_ADD;
    assign imm_ctrl    = sel_legal ? sel_imm : decode_ctrl_pkg::IMM_I;

    always_comb begin
        assert final (imm_ctrl <= decode_ctrl_pkg::IMM_SHAMT)
            else $error("funct_decoder: imm_ctrl %0d out of range", imm_ctrl);
    end

endmodule : funct_decoder

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  var rv_isa_pkg::opcode_t       opcode,
    input  var rv_isa_pkg::funct3_t       funct3,
    input  var rv_isa_pkg::funct7_t       funct7,
    output logic                          reg_write,
    output logic                          mem_write_en,
    output logic                          jump,
    output logic                          branch,
    output decode_ctrl_pkg::result_sel_t  result_sel,
    output logic                          jalr_target,
    output logic                          alu_src_sel_a,
    output logic                          alu_src_sel_b,
    output decode_ctrl_pkg::alu_op_t      alu_op,
    output decode_ctrl_pkg::imm_sel_t     imm_ctrl,
    output logic                          err
);

    // Class goes forward and legality comes back
    decode_ctrl_pkg::instr_class_t instr_class;
    logic                          funct_legal;

    main_decoder main_decoder_i (
        .opcode        (opcode),
        .funct_legal   (funct_legal),
        .instr_class   (instr_class),
        .reg_write     (reg_write),
        .mem_write_en  (mem_write_en),
        .jump          (jump),
        .branch        (branch),
        .jalr_target   (jalr_target),
        .alu_src_sel_a (alu_src_sel_a),
        .alu_src_sel_b (alu_src_sel_b),
        .err           (err),
        .result_sel    (result_sel)
    );

    funct_decoder funct_decoder_i (
        .instr_class (instr_class),
        .funct3      (funct3),
        .funct7      (funct7),
        .alu_op      (alu_op),
        .imm_ctrl    (imm_ctrl),
        .funct_legal (funct_legal)
    );

endmodule : instr_decoder

`default_nettype wire

//--- sim/tb_instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_instr_decoder;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_LIMIT   = 50;
    localparam int DRAIN_LIMIT   = 10;
    localparam int RANDOM_COUNT  = 2000;
    // Opcodes the design leaves unsupported
    localparam rv_isa_pkg::opcode_t OPC_FENCE  = 7'b0001111;
    localparam rv_isa_pkg::opcode_t OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic                         reg_write;
        logic                         mem_write_en;
        logic                         jump;
        logic                         branch;
        decode_ctrl_pkg::result_sel_t result_sel;
        logic                         jalr_target;
        logic                         alu_src_sel_a;
        logic                         alu_src_sel_b;
        decode_ctrl_pkg::alu_op_t     alu_op;
        decode_ctrl_pkg::imm_sel_t    imm_ctrl;
        logic                         err;
    } expect_t;

    logic clk;
    logic rst_n;

    rv_isa_pkg::opcode_t          opcode;
    rv_isa_pkg::funct3_t          funct3;
    rv_isa_pkg::funct7_t          funct7;
    logic                         reg_write;
    logic                         mem_write_en;
    logic                         jump;
    logic                         branch;
    decode_ctrl_pkg::result_sel_t result_sel;
    logic                         jalr_target;
    logic                         alu_src_sel_a;
    logic                         alu_src_sel_b;
    decode_ctrl_pkg::alu_op_t     alu_op;
    decode_ctrl_pkg::imm_sel_t    imm_ctrl;
    logic                         err;

    integer seed;
    int     applied_count;
    int     checked_count;

    rv_isa_pkg::opcode_t opc_list [11];

    instr_decoder instr_decoder_i (
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .reg_write     (reg_write),
        .mem_write_en  (mem_write_en),
        .jump          (jump),
        .branch        (branch),
        .result_sel    (result_sel),
        .jalr_target   (jalr_target),
        .alu_src_sel_a (alu_src_sel_a),
        .alu_src_sel_b (alu_src_sel_b),
        .alu_op        (alu_op),
        .imm_ctrl      (imm_ctrl),
        .err           (err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    task automatic abort_run(input string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // Register-register mapping where alt selects SUB and SRA
    function automatic decode_ctrl_pkg::alu_op_t alu_from_f3(input rv_isa_pkg::funct3_t f3,
                                                            input logic alt);
        case (f3)
            3'b000:  return alt ? decode_ctrl_pkg::ALU_SUB : decode_ctrl_pkg::ALU_ADD;
            3'b001:  return decode_ctrl_pkg::ALU_SLL;
            3'b010:  return decode_ctrl_pkg::ALU_SLT;
            3'b011:  return decode_ctrl_pkg::ALU_SLTU;
            3'b100:  return decode_ctrl_pkg::ALU_XOR;
            3'b101:  return alt ? decode_ctrl_pkg::ALU_SRA : decode_ctrl_pkg::ALU_SRL;
            3'b110:  return decode_ctrl_pkg::ALU_OR;
            default: return decode_ctrl_pkg::ALU_AND;
        endcase
    endfunction

    function automatic decode_ctrl_pkg::alu_op_t compare_op(input rv_isa_pkg::funct3_t f3);
        case (f3)
            3'b000:  return decode_ctrl_pkg::ALU_EQ;
            3'b001:  return decode_ctrl_pkg::ALU_NE;
            3'b100:  return decode_ctrl_pkg::ALU_LT;
            3'b101:  return decode_ctrl_pkg::ALU_GE;
            3'b110:  return decode_ctrl_pkg::ALU_LTU;
            default: return decode_ctrl_pkg::ALU_GEU;
        endcase
    endfunction

    // Expected control word from the decode and legality tables
    function automatic expect_t ref_decode(input rv_isa_pkg::opcode_t opc,
                                           input rv_isa_pkg::funct3_t f3,
                                           input rv_isa_pkg::funct7_t f7);
        expect_t e;
        logic    legal;
        logic    is_base;
        logic    is_alt;
        e       = '0;
        legal   = 1'b1;
        is_base = (f7 == rv_isa_pkg::F7_BASE);
        is_alt  = (f7 == rv_isa_pkg::F7_ALT);
        // Everything except branches and OP takes an immediate
        e.alu_src_sel_b = decode_ctrl_pkg::SRC_B_IMM;
        e.reg_write     = 1'b1;
        case (opc)
            rv_isa_pkg::OPC_LUI: begin
                e.alu_op   = decode_ctrl_pkg::ALU_PASS_B;
                e.imm_ctrl = decode_ctrl_pkg::IMM_U;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                e.alu_src_sel_a = decode_ctrl_pkg::SRC_A_PC;
                e.imm_ctrl      = decode_ctrl_pkg::IMM_U;
            end
            rv_isa_pkg::OPC_JAL: begin
                e.alu_src_sel_a = decode_ctrl_pkg::SRC_A_PC;
                e.jump          = 1'b1;
                e.result_sel    = decode_ctrl_pkg::RES_PC4;
                e.imm_ctrl      = decode_ctrl_pkg::IMM_J;
            end
            rv_isa_pkg::OPC_JALR: begin
                legal         = (f3 == 3'b000);
                e.jump        = 1'b1;
                e.jalr_target = 1'b1;
                e.result_sel  = decode_ctrl_pkg::RES_PC4;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                legal           = (f3[2:1] != 2'b01);
                e.reg_write     = 1'b0;
                e.alu_src_sel_b = decode_ctrl_pkg::SRC_B_RS2;
                e.branch        = 1'b1;
                e.alu_op        = compare_op(f3);
                e.imm_ctrl      = decode_ctrl_pkg::IMM_B;
            end
            rv_isa_pkg::OPC_LOAD: begin
                legal        = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                e.result_sel = decode_ctrl_pkg::RES_MEM;
            end
            rv_isa_pkg::OPC_STORE: begin
                legal          = (f3 <= 3'b010);
                e.reg_write    = 1'b0;
                e.mem_write_en = 1'b1;
                e.imm_ctrl     = decode_ctrl_pkg::IMM_S;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    legal      = is_base || (is_alt && f3 == 3'b101);
                    e.imm_ctrl = decode_ctrl_pkg::IMM_SHAMT;
                    e.alu_op   = alu_from_f3(f3, is_alt);
                end else begin
                    e.alu_op = alu_from_f3(f3, 1'b0);
                end
            end
            rv_isa_pkg::OPC_OP: begin
                legal           = is_base || (is_alt && (f3 == 3'b000 || f3 == 3'b101));
                e.alu_src_sel_b = decode_ctrl_pkg::SRC_B_RS2;
                e.alu_op        = alu_from_f3(f3, is_alt);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (!legal) begin
            e          = '0;
            e.alu_op   = decode_ctrl_pkg::ALU_ADD;
            e.imm_ctrl = decode_ctrl_pkg::IMM_I;
            e.err      = 1'b1;
        end
        return e;
    endfunction

    task automatic report_mismatch(input string field, input int got, input int exp);
        $display("error at %0t ns: %s is %0d, expected %0d (opcode %b funct3 %b funct7 %b)",
                 $time, field, got, exp, opcode, funct3, funct7);
        abort_run("decoder output mismatch");
    endtask

    // Flags go in zero-extended to the result_sel width
    task automatic check_ctrl(input string field,
                              input decode_ctrl_pkg::result_sel_t got,
                              input decode_ctrl_pkg::result_sel_t exp);
        if (got !== exp) begin
            report_mismatch(field, int'(got), int'(exp));
        end
    endtask

    task automatic check_alu_op(input decode_ctrl_pkg::alu_op_t got,
                                input decode_ctrl_pkg::alu_op_t exp);
        if (got !== exp) begin
            report_mismatch("alu_op", int'(got), int'(exp));
        end
    endtask

    task automatic check_imm(input decode_ctrl_pkg::imm_sel_t got,
                             input decode_ctrl_pkg::imm_sel_t exp);
        if (got !== exp) begin
            report_mismatch("imm_ctrl", int'(got), int'(exp));
        end
    endtask

    // Outputs have settled by the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && applied_count > 0) begin
            e = ref_decode(opcode, funct3, funct7);
            check_ctrl("reg_write", {1'b0, reg_write}, {1'b0, e.reg_write});
            check_ctrl("mem_write_en", {1'b0, mem_write_en}, {1'b0, e.mem_write_en});
            check_ctrl("jump", {1'b0, jump}, {1'b0, e.jump});
            check_ctrl("branch", {1'b0, branch}, {1'b0, e.branch});
            check_ctrl("jalr_target", {1'b0, jalr_target}, {1'b0, e.jalr_target});
            check_ctrl("alu_src_sel_a", {1'b0, alu_src_sel_a}, {1'b0, e.alu_src_sel_a});
            check_ctrl("alu_src_sel_b", {1'b0, alu_src_sel_b}, {1'b0, e.alu_src_sel_b});
            check_ctrl("err", {1'b0, err}, {1'b0, e.err});
            check_ctrl("result_sel", result_sel, e.result_sel);
            check_alu_op(alu_op, e.alu_op);
            check_imm(imm_ctrl, e.imm_ctrl);
            checked_count = applied_count;
        end
    end

    task automatic apply_vec(input rv_isa_pkg::opcode_t opc,
                             input rv_isa_pkg::funct3_t f3,
                             input rv_isa_pkg::funct7_t f7);
        @(posedge clk);
        #1;
        opcode = opc;
        funct3 = f3;
        funct7 = f7;
        applied_count++;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_LIMIT) begin
                abort_run("reset was never released");
            end
        end
    endtask

    task automatic wait_checks_done();
        int cycles;
        cycles = 0;
        while (checked_count != applied_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                abort_run("checker fell behind the applied vectors");
            end
        end
    endtask

    // Random funct fields for classes that ignore them or check a single value
    task automatic apply_random_funct(input rv_isa_pkg::opcode_t opc);
        logic [31:0] r;
        r = random_word();
        apply_vec(opc, r[2:0], r[9:3]);
    endtask

    initial begin
        logic [31:0] r;
        int          idx;
        rv_isa_pkg::funct7_t f7;
        seed          = 36;
        applied_count = 0;
        checked_count = 0;
        opcode        = '0;
        funct3        = '0;
        funct7        = '0;
        opc_list      = '{rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL,
                          rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_LOAD,
                          rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP,
                          OPC_FENCE, OPC_SYSTEM};
        wait_reset_release();

        // OP over every funct3 and funct7 pair
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 128; k++) begin
                apply_vec(rv_isa_pkg::OPC_OP, f3[2:0], k[6:0]);
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            r = random_word();
            apply_vec(rv_isa_pkg::OPC_OP_IMM, f3[2:0], rv_isa_pkg::F7_BASE);
            apply_vec(rv_isa_pkg::OPC_OP_IMM, f3[2:0], rv_isa_pkg::F7_ALT);
            apply_vec(rv_isa_pkg::OPC_OP_IMM, f3[2:0], r[6:0]);
        end
        // Branch, load and store across all widths and compare codes
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int n = 0; n < 2; n++) begin
                r = random_word();
                apply_vec(rv_isa_pkg::OPC_BRANCH, f3[2:0], r[6:0]);
                apply_vec(rv_isa_pkg::OPC_LOAD, f3[2:0], r[13:7]);
                apply_vec(rv_isa_pkg::OPC_STORE, f3[2:0], r[20:14]);
            end
        end
        apply_vec(rv_isa_pkg::OPC_JALR, rv_isa_pkg::F3_JALR, rv_isa_pkg::F7_BASE);
        repeat (16) begin
            apply_random_funct(rv_isa_pkg::OPC_LUI);
            apply_random_funct(rv_isa_pkg::OPC_AUIPC);
            apply_random_funct(rv_isa_pkg::OPC_JAL);
            apply_random_funct(rv_isa_pkg::OPC_JALR);
        end
        apply_vec(OPC_FENCE, 3'b000, rv_isa_pkg::F7_BASE);
        apply_vec(OPC_SYSTEM, 3'b000, rv_isa_pkg::F7_BASE);

        // Mostly known opcodes with some fully random ones
        repeat (RANDOM_COUNT) begin
            r = random_word();
            idx = int'(r[15:8]) % 11;
            if (r[20]) begin
                f7 = r[19] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
            end else begin
                f7 = r[27:21];
            end
            if (r[31:30] != 2'b00) begin
                apply_vec(opc_list[idx], r[2:0], f7);
            end else begin
                apply_vec(r[6:0], r[2:0], f7);
            end
        end

        wait_checks_done();
        if (checked_count == applied_count && applied_count > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("no vectors were checked");
        end
    end

endmodule : tb_instr_decoder

`default_nettype wire

//--- sim.f
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/main_decoder.sv
design/funct_decoder.sv
design/instr_decoder.sv
sim/tb_instr_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the instr_decoder testbench with Verilator and runs it.
# The exit status is the simulation result.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_instr_decoder \
    -f sim.f \
    -o tb_instr_decoder \
    && ./obj_dir/tb_instr_decoder \
    || { echo "simulation failed"; exit 1; }
